/* hdl/calsoc_pkg.sv */
package calsoc_pkg;

	////////////////////////////////////////////////////////////////////////////
	// bus and measurement types
	////////////////////////////////////////////////////////////////////////////
	typedef logic [31:0] wb_addr_t;
	typedef logic [31:0] wb_data_t;
	typedef logic [3:0]  wb_sel_t;
	typedef logic [15:0] dac_word_t;
	typedef logic [9:0]  delay_code_t;
	typedef logic [7:0]  mu_offset_t;

	// address map
	localparam wb_addr_t RAM_BASE = 32'h0000_0000;
	localparam wb_addr_t RAM_MASK = 32'hFF00_0000;
	localparam wb_addr_t MU_BASE  = 32'h0500_0000;
	localparam wb_addr_t MU_MASK  = 32'hFF00_0000;

	localparam int RAM_WORDS = 256;

	// sweep timing, in wb_clk_i cycles
	localparam int DAC_SPI_CLK_DIV    = 10;
	localparam int DAC_DIV_W          = $clog2(DAC_SPI_CLK_DIV);
	localparam int DAC_SETTLE_CYCLES  = 3;
	localparam int STROBE_HOLD_CYCLES = 5;

	// measure unit register offsets
	localparam mu_offset_t MU_CTRL       = 8'h00;
	localparam mu_offset_t MU_STATUS     = 8'h04;
	localparam mu_offset_t MU_THR_START  = 8'h08;
	localparam mu_offset_t MU_THR_DELTA  = 8'h0C;
	localparam mu_offset_t MU_STEP_LIMIT = 8'h10;
	localparam mu_offset_t MU_DELAY_CODE = 8'h14;
	localparam mu_offset_t MU_RESULT     = 8'h18;

endpackage

/* hdl/wb_if.sv */
`timescale 1ns/1ps

interface wb_if;

	logic                 cyc;
	logic                 stb;
	logic                 we;
	calsoc_pkg::wb_addr_t adr;
	calsoc_pkg::wb_data_t dat_w;
	calsoc_pkg::wb_sel_t  sel;
	calsoc_pkg::wb_data_t dat_r;
	logic                 ack;

	// request side
	modport master (
		output cyc, stb, we, adr, dat_w, sel,
		input  dat_r, ack
	);

	// response side
	modport slave (
		input  cyc, stb, we, adr, dat_w, sel,
		output dat_r, ack
	);

endinterface

/* hdl/wb_decoder.sv */
`timescale 1ns/1ps

module wb_decoder (
	input  logic                 wb_clk_i,
	input  logic                 rst_n_i,
	input  calsoc_pkg::wb_addr_t m_adr_i,
	input  logic                 m_cyc_i,
	input  logic                 m_stb_i,
	output logic                 err_o,
	wb_if.slave                  m_bus,
	wb_if.master                 ram_bus,
	wb_if.master                 mu_bus
);

	logic ram_hit;
	logic mu_hit;
	logic miss_req;
	logic err_q;

	// region match under each mask
	assign ram_hit = (m_adr_i & calsoc_pkg::RAM_MASK) == calsoc_pkg::RAM_BASE;
	assign mu_hit  = (m_adr_i & calsoc_pkg::MU_MASK) == calsoc_pkg::MU_BASE;

	assign miss_req = m_cyc_i && m_stb_i && !ram_hit && !mu_hit;

	////////////////////////////////////////////////////////////////////////////
	// request fan-out
	////////////////////////////////////////////////////////////////////////////
	assign ram_bus.cyc   = m_bus.cyc && ram_hit;
	assign ram_bus.stb   = m_bus.stb && ram_hit;
	assign ram_bus.we    = m_bus.we;
	assign ram_bus.adr   = m_bus.adr;
	assign ram_bus.dat_w = m_bus.dat_w;
	assign ram_bus.sel   = m_bus.sel;

	assign mu_bus.cyc   = m_bus.cyc && mu_hit;
	assign mu_bus.stb   = m_bus.stb && mu_hit;
	assign mu_bus.we    = m_bus.we;
	assign mu_bus.adr   = m_bus.adr;
	assign mu_bus.dat_w = m_bus.dat_w;
	assign mu_bus.sel   = m_bus.sel;

	// response mux, address is held until the response
	always_comb begin
		if (ram_hit) begin
			m_bus.ack   = ram_bus.ack;
			m_bus.dat_r = ram_bus.dat_r;
		end else if (mu_hit) begin
			m_bus.ack   = mu_bus.ack;
			m_bus.dat_r = mu_bus.dat_r;
		end else begin
			m_bus.ack   = 1'b0;
			m_bus.dat_r = '0;
		end
	end

	// single err pulse per unmapped strobe
	always_ff @(posedge wb_clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			err_q <= 1'b0;
		end else begin
			err_q <= miss_req && !err_q;
		end
	end

	assign err_o = err_q;

endmodule

/* hdl/wb_ram.sv */
`timescale 1ns/1ps

module wb_ram #(
	parameter int WORDS = calsoc_pkg::RAM_WORDS
) (
	input  logic wb_clk_i,
	input  logic rst_n_i,
	wb_if.slave  bus
);

	localparam int AW = (WORDS > 1) ? $clog2(WORDS) : 1;

	calsoc_pkg::wb_data_t mem [WORDS];
	calsoc_pkg::wb_data_t dat_r_q;
	logic [AW-1:0]        word_idx;
	logic                 access;
	logic                 ack_q;

	// word index wraps at the depth
	assign word_idx = AW'((bus.adr >> 2) % WORDS);
	assign access   = bus.cyc && bus.stb && !ack_q;

	always_ff @(posedge wb_clk_i) begin
		if (access) begin
			if (bus.we) begin
				for (int lane = 0; lane < 4; lane++) begin
					if (bus.sel[lane]) begin
						mem[word_idx][lane*8 +: 8] <= bus.dat_w[lane*8 +: 8];
					end
				end
			end
			dat_r_q <= mem[word_idx];
		end
	end

	always_ff @(posedge wb_clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			ack_q <= 1'b0;
		end else begin
			ack_q <= access;
		end
	end

	assign bus.ack   = ack_q;
	assign bus.dat_r = dat_r_q;

endmodule

/* hdl/dac_spi.sv */
`timescale 1ns/1ps

module dac_spi (
	input  logic                  wb_clk_i,
	input  logic                  rst_n_i,
	input  logic                  start_i,
	input  calsoc_pkg::dac_word_t word_i,
	output logic                  busy_o,
	output logic                  done_o,
	output logic                  dac_sync_o,
	output logic                  dac_sclk_o,
	output logic                  dac_sdi_o
);

	logic [calsoc_pkg::DAC_DIV_W-1:0] div_cnt_q;
	logic [3:0]                       bit_cnt_q;
	calsoc_pkg::dac_word_t            shift_q;
	logic                             active_q;
	logic                             sclk_q;
	logic                             done_q;
	logic                             tick;

	// half period of sclk elapsed
	assign tick = active_q &&
		(div_cnt_q == calsoc_pkg::DAC_DIV_W'(calsoc_pkg::DAC_SPI_CLK_DIV - 1));

	always_ff @(posedge wb_clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			div_cnt_q <= '0;
			bit_cnt_q <= '0;
			shift_q   <= '0;
			active_q  <= 1'b0;
			sclk_q    <= 1'b0;
			done_q    <= 1'b0;
		end else begin
			done_q <= 1'b0;
			if (!active_q) begin
				if (start_i) begin
					active_q  <= 1'b1;
					shift_q   <= word_i;
					div_cnt_q <= '0;
					bit_cnt_q <= '0;
					sclk_q    <= 1'b0;
				end
			end else if (tick) begin
				div_cnt_q <= '0;
				sclk_q    <= !sclk_q;
				// falling edge moves sdi to the next bit
				if (sclk_q) begin
					shift_q   <= shift_q << 1;
					bit_cnt_q <= bit_cnt_q + 4'd1;
					if (bit_cnt_q == 4'd15) begin
						active_q <= 1'b0;
						done_q   <= 1'b1;
					end
				end
			end else begin
				div_cnt_q <= div_cnt_q + 1'b1;
			end
		end
	end

	assign busy_o     = active_q;
	assign done_o     = done_q;
	assign dac_sync_o = !active_q;
	assign dac_sclk_o = sclk_q;
	assign dac_sdi_o  = shift_q[15];

endmodule

/* hdl/measure_unit.sv */
`timescale 1ns/1ps

module measure_unit (
	input  logic                    wb_clk_i,
	input  logic                    rst_n_i,
	input  logic                    cmp_out_i,
	wb_if.slave                     bus,
	output logic                    dac_sync_o,
	output logic                    dac_sclk_o,
	output logic                    dac_sdi_o,
	output calsoc_pkg::delay_code_t delay_code_o,
	output logic                    delay_stb_o
);

	typedef enum logic [2:0] {IDLE, LOAD, SETTLE, STROBE, NEXT} sweep_state_e;

	sweep_state_e            state_q;
	calsoc_pkg::dac_word_t   thr_start_q, thr_delta_q, thr_q, result_q;
	logic [15:0]             limit_q, step_q;
	calsoc_pkg::delay_code_t delay_code_q;
	logic [7:0]              wait_q;
	logic                    found_q, done_q, ack_q, spi_start_q;
	logic                    spi_busy, spi_done, busy;
	logic                    access, bus_wr, start_req;
	calsoc_pkg::mu_offset_t  offset;
	calsoc_pkg::wb_data_t    rd_data, dat_r_q;

	assign offset    = bus.adr[7:0];
	assign access    = bus.cyc && bus.stb && !ack_q;
	assign bus_wr    = access && bus.we;
	assign start_req = bus_wr && (offset == calsoc_pkg::MU_CTRL) && bus.dat_w[0];
	assign busy      = (state_q != IDLE) || spi_busy;

	////////////////////////////////////////////////////////////////////////////
	// register bank
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge wb_clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			thr_start_q  <= '0;
			thr_delta_q  <= '0;
			limit_q      <= '0;
			delay_code_q <= '0;
			ack_q        <= 1'b0;
		end else begin
			ack_q <= access;
			if (bus_wr) begin
				case (offset)
					calsoc_pkg::MU_THR_START:  thr_start_q  <= bus.dat_w[15:0];
					calsoc_pkg::MU_THR_DELTA:  thr_delta_q  <= bus.dat_w[15:0];
					calsoc_pkg::MU_STEP_LIMIT: limit_q      <= bus.dat_w[15:0];
					calsoc_pkg::MU_DELAY_CODE: delay_code_q <= bus.dat_w[9:0];
					default: ;
				endcase
			end
		end
	end

	always_comb begin
		case (offset)
			calsoc_pkg::MU_STATUS:     rd_data = {29'd0, done_q, found_q, busy};
			calsoc_pkg::MU_THR_START:  rd_data = {16'd0, thr_start_q};
			calsoc_pkg::MU_THR_DELTA:  rd_data = {16'd0, thr_delta_q};
			calsoc_pkg::MU_STEP_LIMIT: rd_data = {16'd0, limit_q};
			calsoc_pkg::MU_DELAY_CODE: rd_data = {22'd0, delay_code_q};
			calsoc_pkg::MU_RESULT:     rd_data = {16'd0, result_q};
			default:                   rd_data = '0;
		endcase
	end

	always_ff @(posedge wb_clk_i) begin
		if (access) begin
			dat_r_q <= rd_data;
		end
	end

	assign bus.ack   = ack_q;
	assign bus.dat_r = dat_r_q;

	////////////////////////////////////////////////////////////////////////////
	// sweep FSM
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge wb_clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state_q     <= IDLE;
			thr_q       <= '0;
			step_q      <= '0;
			wait_q      <= '0;
			result_q    <= '0;
			found_q     <= 1'b0;
			done_q      <= 1'b0;
			spi_start_q <= 1'b0;
		end else begin
			spi_start_q <= 1'b0;
			case (state_q)
				IDLE: begin
					if (start_req) begin
						found_q <= 1'b0;
						// zero limit finishes without a frame
						if (limit_q == '0) begin
							done_q <= 1'b1;
						end else begin
							done_q      <= 1'b0;
							thr_q       <= thr_start_q;
							step_q      <= '0;
							spi_start_q <= 1'b1;
							state_q     <= LOAD;
						end
					end
				end
				LOAD: begin
					if (spi_done) begin
						wait_q  <= '0;
						state_q <= SETTLE;
					end
				end
				SETTLE: begin
					if (wait_q == 8'(calsoc_pkg::DAC_SETTLE_CYCLES - 1)) begin
						wait_q  <= '0;
						state_q <= STROBE;
					end else begin
						wait_q <= wait_q + 8'd1;
					end
				end
				STROBE: begin
					if (wait_q == 8'(calsoc_pkg::STROBE_HOLD_CYCLES - 1)) begin
						// comparator sampled in the last strobe cycle
						result_q <= thr_q;
						if (cmp_out_i) begin
							found_q <= 1'b1;
							done_q  <= 1'b1;
							state_q <= IDLE;
						end else begin
							state_q <= NEXT;
						end
					end else begin
						wait_q <= wait_q + 8'd1;
					end
				end
				NEXT: begin
					if (step_q == limit_q - 16'd1) begin
						done_q  <= 1'b1;
						state_q <= IDLE;
					end else begin
						step_q      <= step_q + 16'd1;
						thr_q       <= thr_q + thr_delta_q;
						spi_start_q <= 1'b1;
						state_q     <= LOAD;
					end
				end
				default: state_q <= IDLE;
			endcase
		end
	end

	assign delay_stb_o  = (state_q == STROBE);
	assign delay_code_o = delay_code_q;

	dac_spi u_dac_spi (
		.wb_clk_i   (wb_clk_i),
		.rst_n_i    (rst_n_i),
		.start_i    (spi_start_q),
		.word_i     (thr_q),
		.busy_o     (spi_busy),
		.done_o     (spi_done),
		.dac_sync_o (dac_sync_o),
		.dac_sclk_o (dac_sclk_o),
		.dac_sdi_o  (dac_sdi_o)
	);

endmodule

/* hdl/calsoc_top.sv */
`timescale 1ns/1ps

module calsoc_top (
	input  logic                    wb_clk_i,
	input  logic                    rst_n_i,
	input  logic                    wb_cyc_i,
	input  logic                    wb_stb_i,
	input  logic                    wb_we_i,
	input  calsoc_pkg::wb_addr_t    wb_adr_i,
	input  calsoc_pkg::wb_data_t    wb_dat_i,
	input  calsoc_pkg::wb_sel_t     wb_sel_i,
	input  logic                    cmp_out_i,
	output calsoc_pkg::wb_data_t    wb_dat_o,
	output logic                    wb_ack_o,
	output logic                    wb_err_o,
	output logic                    dac_sync_o,
	output logic                    dac_sclk_o,
	output logic                    dac_sdi_o,
	output calsoc_pkg::delay_code_t delay_code_o,
	output logic                    delay_stb_o
);

	wb_if m_bus ();
	wb_if ram_bus ();
	wb_if mu_bus ();

	////////////////////////////////////////////////////////////////////////////
	// master side from the external bus
	////////////////////////////////////////////////////////////////////////////
	assign m_bus.cyc   = wb_cyc_i;
	assign m_bus.stb   = wb_stb_i;
	assign m_bus.we    = wb_we_i;
	assign m_bus.adr   = wb_adr_i;
	assign m_bus.dat_w = wb_dat_i;
	assign m_bus.sel   = wb_sel_i;

	assign wb_dat_o = m_bus.dat_r;
	assign wb_ack_o = m_bus.ack;

	wb_decoder u_decoder (
		.wb_clk_i (wb_clk_i),
		.rst_n_i  (rst_n_i),
		.m_adr_i  (wb_adr_i),
		.m_cyc_i  (wb_cyc_i),
		.m_stb_i  (wb_stb_i),
		.err_o    (wb_err_o),
		.m_bus    (m_bus.slave),
		.ram_bus  (ram_bus.master),
		.mu_bus   (mu_bus.master)
	);

	wb_ram #(
		.WORDS (calsoc_pkg::RAM_WORDS)
	) u_ram (
		.wb_clk_i (wb_clk_i),
		.rst_n_i  (rst_n_i),
		.bus      (ram_bus.slave)
	);

	// threshold sweep with dac and delay line
	measure_unit u_measure (
		.wb_clk_i     (wb_clk_i),
		.rst_n_i      (rst_n_i),
		.cmp_out_i    (cmp_out_i),
		.bus          (mu_bus.slave),
		.dac_sync_o   (dac_sync_o),
		.dac_sclk_o   (dac_sclk_o),
		.dac_sdi_o    (dac_sdi_o),
		.delay_code_o (delay_code_o),
		.delay_stb_o  (delay_stb_o)
	);

endmodule

/* tb/calsoc_assert.sv */
`timescale 1ns/1ps

module calsoc_assert (
	input logic clk_i,
	input logic rst_n_i,
	input logic cyc_i,
	input logic stb_i,
	input logic ack_i,
	input logic err_i,
	input logic sync_i,
	input logic strobe_i
);

	int strobe_len_q;
	int fail_count = 0;

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			strobe_len_q <= 0;
		end else if (strobe_i) begin
			strobe_len_q <= strobe_len_q + 1;
		end else begin
			strobe_len_q <= 0;
		end
	end

	ack_err_excl: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		!(ack_i && err_i))
		else begin
			fail_count++;
			$error("ack and err high together");
		end

	// no stall, the response follows the first strobe cycle
	resp_next: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		(cyc_i && stb_i && !(ack_i || err_i)) |=> (ack_i || err_i))
		else begin
			fail_count++;
			$error("strobe without response");
		end

	resp_single: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		(ack_i || err_i) |=> !(ack_i || err_i))
		else begin
			fail_count++;
			$error("second response");
		end

	sync_in_strobe: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		strobe_i |-> sync_i)
		else begin
			fail_count++;
			$error("sync low during strobe");
		end

	strobe_width: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		$fell(strobe_i) |-> (strobe_len_q == calsoc_pkg::STROBE_HOLD_CYCLES))
		else begin
			fail_count++;
			$error("strobe width wrong");
		end

endmodule

bind calsoc_top calsoc_assert u_assert (
	.clk_i    (wb_clk_i),
	.rst_n_i  (rst_n_i),
	.cyc_i    (wb_cyc_i),
	.stb_i    (wb_stb_i),
	.ack_i    (wb_ack_o),
	.err_i    (wb_err_o),
	.sync_i   (dac_sync_o),
	.strobe_i (delay_stb_o)
);

/* tb/calsoc_checker.sv */
`timescale 1ns/1ps

module calsoc_checker (
	input  logic                    clk_i,
	input  logic                    rst_n_i,
	input  logic                    ack_i,
	input  logic                    err_i,
	input  calsoc_pkg::wb_data_t    dat_i,
	input  logic                    sync_i,
	input  logic                    sclk_i,
	input  logic                    sdi_i,
	input  calsoc_pkg::delay_code_t delay_code_i,
	input  logic                    delay_stb_i,
	output calsoc_pkg::dac_word_t   last_frame_o,
	output logic                    frame_seen_o
);

	int                    errors = 0;
	calsoc_pkg::dac_word_t exp_frames[$];
	calsoc_pkg::dac_word_t shift = '0;
	int                    nbits = 0;
	int                    strobes_exp = 0;
	int                    strobes_seen = 0;
	logic                  stb_prev = 1'b0;
	logic                  rsp_pending = 1'b0;
	logic                  rsp_err = 1'b0;
	logic                  rsp_chk = 1'b0;
	calsoc_pkg::wb_data_t  rsp_data = '0;

	initial begin
		last_frame_o = '0;
		frame_seen_o = 1'b0;
	end

	task automatic flag_mismatch(input string msg);
		errors++;
		$display("ERROR at %0d ns: %s", $time, msg);
	endtask

	task automatic expect_frame(input calsoc_pkg::dac_word_t w);
		exp_frames.push_back(w);
		strobes_exp++;
	endtask

	task automatic expect_response(input logic err, input logic chk,
		input calsoc_pkg::wb_data_t d);
		rsp_pending = 1'b1;
		rsp_err     = err;
		rsp_chk     = chk;
		rsp_data    = d;
	endtask

	task automatic check_delay(input calsoc_pkg::delay_code_t exp);
		if (delay_code_i !== exp)
			flag_mismatch($sformatf("delay code %h, expected %h", delay_code_i, exp));
	endtask

	task automatic check_sweep_done();
		if (exp_frames.size() != 0)
			flag_mismatch($sformatf("%0d expected frames missing", exp_frames.size()));
		if (strobes_seen != strobes_exp)
			flag_mismatch($sformatf("%0d delay strobes, expected %0d", strobes_seen,
				strobes_exp));
		exp_frames.delete();
		strobes_seen = 0;
		strobes_exp  = 0;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// bus responses
	////////////////////////////////////////////////////////////////////////////
	always @(posedge clk_i) begin
		if (rst_n_i && (ack_i || err_i)) begin
			if (!rsp_pending) begin
				flag_mismatch("response without a pending access");
			end else if (err_i !== rsp_err) begin
				flag_mismatch($sformatf("err %b, expected %b", err_i, rsp_err));
			end else if (rsp_chk && dat_i !== rsp_data) begin
				flag_mismatch($sformatf("read data %h, expected %h", dat_i, rsp_data));
			end
			rsp_pending = 1'b0;
		end
	end

	// one delay line strobe follows every frame
	always @(posedge clk_i) begin
		if (rst_n_i && delay_stb_i && !stb_prev)
			strobes_seen++;
		stb_prev = delay_stb_i;
	end

	// dac frames, MSB first on rising sclk
	always @(posedge sclk_i) begin
		if (!sync_i) begin
			shift = {shift[14:0], sdi_i};
			nbits++;
			if (nbits == 16) begin
				nbits        = 0;
				last_frame_o = shift;
				frame_seen_o = 1'b1;
				if (exp_frames.size() == 0)
					flag_mismatch($sformatf("unexpected frame %h", shift));
				else if (exp_frames.pop_front() !== shift)
					flag_mismatch($sformatf("frame %h out of sequence", shift));
			end
		end
	end

endmodule

/* tb/calsoc_tb.sv */
`timescale 1ns/1ps

module calsoc_tb;

	localparam int PAT_WORDS   = 8 * 64;
	localparam int BUS_TIMEOUT = 16;
	localparam int SWEEP_POLLS = 2000;

	logic clk, rst_n, cyc, stb, we, cmp_out;
	calsoc_pkg::wb_addr_t    adr;
	calsoc_pkg::wb_data_t    dat_w, dat_r;
	calsoc_pkg::wb_sel_t     sel;
	logic                    ack, err, sync, sclk, sdi, dstb;
	calsoc_pkg::delay_code_t dcode;
	calsoc_pkg::dac_word_t   last_frame, target;
	logic                    frame_seen, timed_out;
	logic [31:0]             pat [PAT_WORDS];
	calsoc_pkg::wb_data_t    scratch;
	int                      idx;

	calsoc_top u_dut (
		.wb_clk_i (clk), .rst_n_i (rst_n), .wb_cyc_i (cyc), .wb_stb_i (stb),
		.wb_we_i (we), .wb_adr_i (adr), .wb_dat_i (dat_w), .wb_sel_i (sel),
		.cmp_out_i (cmp_out), .wb_dat_o (dat_r), .wb_ack_o (ack), .wb_err_o (err),
		.dac_sync_o (sync), .dac_sclk_o (sclk), .dac_sdi_o (sdi),
		.delay_code_o (dcode), .delay_stb_o (dstb)
	);

	calsoc_checker u_chk (
		.clk_i (clk), .rst_n_i (rst_n), .ack_i (ack), .err_i (err), .dat_i (dat_r),
		.sync_i (sync), .sclk_i (sclk), .sdi_i (sdi), .delay_code_i (dcode),
		.delay_stb_i (dstb),
		.last_frame_o (last_frame), .frame_seen_o (frame_seen)
	);

	// comparator trips once the dac holds the target or more
	always @(posedge clk) begin
		#2;
		cmp_out = frame_seen && (last_frame >= target);
	end

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	function automatic calsoc_pkg::wb_addr_t mu_addr(input calsoc_pkg::mu_offset_t off);
		return calsoc_pkg::MU_BASE | 32'(off);
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// bus driver
	////////////////////////////////////////////////////////////////////////////
	task automatic bus_access(input logic wr, input calsoc_pkg::wb_addr_t a,
		input calsoc_pkg::wb_data_t d, input calsoc_pkg::wb_sel_t s,
		output calsoc_pkg::wb_data_t rdata);
		int   cycles;
		logic seen;
		cycles = 0;
		seen   = 1'b0;
		cyc    = 1'b1;
		stb    = 1'b1;
		we     = wr;
		adr    = a;
		dat_w  = d;
		sel    = s;
		while (!seen && cycles < BUS_TIMEOUT) begin
			@(posedge clk);
			#2;
			cycles++;
			seen = ack || err;
		end
		rdata = dat_r;
		cyc   = 1'b0;
		stb   = 1'b0;
		we    = 1'b0;
		if (!seen) begin
			$display("bus access to %h got neither ack nor err in time", a);
			timed_out = 1'b1;
		end
		@(posedge clk);
		#2;
	endtask

	task automatic write_word(input calsoc_pkg::wb_addr_t a, input calsoc_pkg::wb_data_t d,
		input calsoc_pkg::wb_sel_t s, input logic exp_err);
		calsoc_pkg::wb_data_t unused;
		u_chk.expect_response(exp_err, 1'b0, '0);
		bus_access(1'b1, a, d, s, unused);
		if (!exp_err && a == mu_addr(calsoc_pkg::MU_DELAY_CODE))
			u_chk.check_delay(d[9:0]);
	endtask

	task automatic read_word(input calsoc_pkg::wb_addr_t a, input logic exp_err,
		input logic chk, input calsoc_pkg::wb_data_t exp, output calsoc_pkg::wb_data_t rd);
		u_chk.expect_response(exp_err, chk, exp);
		bus_access(1'b0, a, '0, 4'hf, rd);
	endtask

	task automatic run_sweep(input int base, input logic busy_start);
		calsoc_pkg::dac_word_t thr;
		calsoc_pkg::wb_data_t  status;
		int                    polls;
		logic                  hit;
		thr = pat[base+1][15:0];
		hit = 1'b0;
		// frames follow start + k*delta until the first trip
		for (int k = 0; k < int'(pat[base+3][15:0]) && !hit; k++) begin
			u_chk.expect_frame(thr);
			hit = thr >= pat[base+4][15:0];
			thr = thr + pat[base+2][15:0];
		end
		target = pat[base+4][15:0];
		write_word(mu_addr(calsoc_pkg::MU_THR_START), pat[base+1], 4'hf, 1'b0);
		write_word(mu_addr(calsoc_pkg::MU_THR_DELTA), pat[base+2], 4'hf, 1'b0);
		write_word(mu_addr(calsoc_pkg::MU_STEP_LIMIT), pat[base+3], 4'hf, 1'b0);
		write_word(mu_addr(calsoc_pkg::MU_DELAY_CODE), pat[base+5], 4'hf, 1'b0);
		write_word(mu_addr(calsoc_pkg::MU_CTRL), 32'h1, 4'hf, 1'b0);
		if (busy_start)
			write_word(mu_addr(calsoc_pkg::MU_CTRL), 32'h1, 4'hf, 1'b0);
		polls  = 0;
		status = '0;
		while (!status[2] && polls < SWEEP_POLLS && !timed_out) begin
			read_word(mu_addr(calsoc_pkg::MU_STATUS), 1'b0, 1'b0, '0, status);
			polls++;
		end
		if (!status[2] && !timed_out) begin
			$display("sweep did not finish within %0d status polls", SWEEP_POLLS);
			timed_out = 1'b1;
		end
		read_word(mu_addr(calsoc_pkg::MU_STATUS), 1'b0, 1'b1,
			{29'd0, 1'b1, pat[base+6][0], 1'b0}, status);
		read_word(mu_addr(calsoc_pkg::MU_RESULT), 1'b0, 1'b1, pat[base+7], status);
		u_chk.check_sweep_done();
	endtask

	initial begin
		rst_n     = 1'b0;
		cyc       = 1'b0;
		stb       = 1'b0;
		we        = 1'b0;
		adr       = '0;
		dat_w     = '0;
		sel       = '0;
		cmp_out   = 1'b0;
		target    = '0;
		timed_out = 1'b0;
		for (int i = 0; i < PAT_WORDS; i++)
			pat[i] = '0;
		$readmemh("tb/calsoc_patterns.txt", pat);
		repeat (10) @(posedge clk);
		#2;
		rst_n = 1'b1;
		@(posedge clk);
		#2;
		idx = 0;
		while (!timed_out && idx < PAT_WORDS && pat[idx] != 0) begin
			case (pat[idx])
				1: write_word(pat[idx+1], pat[idx+2], pat[idx+3][3:0], pat[idx+4][0]);
				2: read_word(pat[idx+1], pat[idx+4][0], !pat[idx+4][0], pat[idx+5], scratch);
				3: run_sweep(idx, 1'b0);
				4: run_sweep(idx, 1'b1);
				default: begin
					$display("unknown pattern type %0d", pat[idx]);
					timed_out = 1'b1;
				end
			endcase
			idx += 8;
		end
		$display("checker errors: %0d, assertion failures: %0d, aborted: %0d",
			u_chk.errors, u_dut.u_assert.fail_count, timed_out);
		if (timed_out || u_chk.errors != 0 || u_dut.u_assert.fail_count != 0) begin
			$display("*** TEST FAILED ***");
		end else begin
			$display("*** TEST PASSED ***");
		end
		$finish;
	end

endmodule

/* calsoc.f */
hdl/calsoc_pkg.sv
hdl/wb_if.sv
hdl/wb_decoder.sv
hdl/wb_ram.sv
hdl/dac_spi.sv
hdl/measure_unit.sv
hdl/calsoc_top.sv
tb/calsoc_assert.sv
tb/calsoc_checker.sv
tb/calsoc_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the calsoc testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
	--top-module calsoc_tb \
	--Mdir obj_dir -o calsoc_sim \
	-f calsoc.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/calsoc_sim > sim.log 2>&1
sim_status=$?
cat sim.log

if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if grep -q '\*\*\* TEST FAILED \*\*\*' sim.log; then
	exit 1
fi

exit 0

/* tb/calsoc_patterns.txt */
// type addr/start data/delta sel/limit err/target exp/dcode found result
// type 1 write, 2 read, 3 sweep, 4 sweep with a second start while busy, 0 end
1 00000000 11223344 f 0 00000000 0 0
2 00000000 00000000 f 0 11223344 0 0
1 00000000 aabbccdd 5 0 00000000 0 0
2 00000000 00000000 f 0 11bb33dd 0 0
1 00000404 cafef00d f 0 00000000 0 0
2 00000004 00000000 f 0 cafef00d 0 0
1 000003fc 01020304 f 0 00000000 0 0
2 000003fc 00000000 f 0 01020304 0 0
1 05000008 00001234 f 0 00000000 0 0
2 05000008 00000000 f 0 00001234 0 0
1 0500000c 0000abcd f 0 00000000 0 0
2 0500000c 00000000 f 0 0000abcd 0 0
1 05000010 00000007 f 0 00000000 0 0
2 05000010 00000000 f 0 00000007 0 0
1 05000014 0000fabc f 0 00000000 0 0
2 05000014 00000000 f 0 000002bc 0 0
2 05000018 00000000 f 0 00000000 0 0
2 05000004 00000000 f 0 00000000 0 0
1 10000004 deadbeef f 1 00000000 0 0
2 10000000 00000000 f 1 00000000 0 0
1 06000008 00005555 f 1 00000000 0 0
2 00000004 00000000 f 0 cafef00d 0 0
2 05000008 00000000 f 0 00001234 0 0
3 00000100 00000040 8 00000200 00000155 1 00000200
3 00000000 00000100 3 00000800 0000002a 0 00000200
3 00001000 00000000 0 00000000 00000011 0 00000200
4 0000fff0 00000008 4 0000fff9 000003ff 0 00000008
3 0000ff00 00000100 5 00000000 00000001 1 0000ff00
0 00000000 00000000 0 00000000 00000000 0 00000000
